/* sim/dbg_stim.txt */
# debug unit stimulus, one operation per line, op then three hex fields
#   wr    addr   wdata    -      bus write, read data must be zero
#   rd    addr   expdata  -      bus read, compare with expdata
#   hpin  rpin   -        -      one-cycle halt or resume pin pulse
#   trap  cause  -        -      one-cycle trap with exception cause
#   whalt level  -        -      wait for debug_halted_o to reach level
#   pcs   pc_if  pc_id    sleep  drive core status
#   stall level and set value    check stall_o and settings_o {sste,ecall,elsu,ebrk,eill}
#   rfw   index  data     -      exactly one regfile write, rfn none
#   jmp   addr   -        -      exactly one jump pulse, jn none
# reset values
rd    0000  00000000  0
rd    000C  0000001F  0
rd    0004  00000000  0
set   00    0         0
stall 0     0         0
# halt by DBG_CTRL write with sste
wr    0000  00010001  0
whalt 1     0         0
rd    0000  00010001  0
stall 1     0         0
rd    000C  0000001F  0
set   10    0         0
# exception enables
wr    0008  0000008C  0
rd    0008  000000AC  0
set   17    0         0
# gpr access while halted
wr    041C  12345678  0
rfw   07    12345678  0
rd    0424  09090909  0
rd    041C  07070707  0
# halted-only registers
pcs   00000100  000000FC  0
rd    2000  00000100  0
rd    2004  000000FC  0
wr    2000  00000200  0
jmp   00000200  0     0
# resume by DBG_CTRL write, sste cleared
wr    0000  00000000  0
whalt 0     0         0
stall 0     0         0
rd    0000  00000000  0
set   07    0         0
# gpr and dnpc while running
wr    041C  AAAA5555  0
rfn   0     0         0
rd    0424  00000000  0
wr    2000  00000300  0
jn    0     0         0
# trap with single step
wr    0000  00000001  0
set   17    0         0
trap  03    0         0
whalt 1     0         0
rd    000C  00000003  0
rd    0004  00000001  0
pcs   00000100  000000FC  1
rd    0004  00010001  0
wr    0004  00000001  0
rd    0004  00010000  0
pcs   00000100  000000FC  0
# resume and halt by pins
rpin  0     0         0
whalt 0     0         0
rd    000C  00000003  0
rd    0004  00000000  0
hpin  0     0         0
whalt 1     0         0
stall 1     0         0
rd    000C  0000001F  0
rd    0000  00010001  0
rpin  0     0         0
whalt 0     0         0
stall 0     0         0
# grant rule, unmapped and csr addresses
rd    1000  00000000  0
wr    1000  FFFFFFFF  0
rd    4300  00000000  0
wr    4004  00001234  0
rd    0010  00000000  0

/* sim/tb_dbg_unit.sv */
/*
 * debug unit testbench
 * runs bus operations, pin events and checks from a stim file,
 * with a register file model and a core acknowledge model
 */

`timescale 1ns/1ps
`include "dbg_cfg.svh"

module tb_dbg_unit;

  localparam int TMO = 50;  // max cycles per wait

  logic                      clk;
  logic                      rst_n;
  logic                      debug_req_i, debug_we_i;
  logic                      debug_gnt_o, debug_rvalid_o;
  logic [`DBG_ADDR_W-1:0]    debug_addr_i;
  logic [`DBG_DATA_W-1:0]    debug_wdata_i, debug_rdata_o;
  logic                      debug_halted_o, debug_halt_i, debug_resume_i;
  dbg_pkg::dbg_settings_t    settings_o;
  logic                      trap_i;
  logic [`DBG_CAUSE_W-1:0]   exc_cause_i;
  logic                      stall_o, dbg_req_o, dbg_ack_i;
  logic                      regfile_rreq_o, regfile_wreq_o;
  logic [`DBG_RF_ADDR_W-1:0] regfile_raddr_o, regfile_waddr_o;
  logic [`DBG_DATA_W-1:0]    regfile_rdata_i, regfile_wdata_o;
  logic [`DBG_DATA_W-1:0]    pc_if_i, pc_id_i;
  logic                      sleeping_i;
  logic                      jump_req_o;
  logic [`DBG_DATA_W-1:0]    jump_addr_o;

  int errors;    // wrong values
  int timeouts;  // waits that ran out
  logic [`DBG_RF_ADDR_W+`DBG_DATA_W-1:0] rf_writes[$];  // {addr, data}
  logic [`DBG_DATA_W-1:0]                jumps[$];

  dbg_unit i_dut (
    .clk(clk), .rst_n(rst_n),
    .debug_req_i(debug_req_i), .debug_gnt_o(debug_gnt_o),
    .debug_rvalid_o(debug_rvalid_o), .debug_addr_i(debug_addr_i),
    .debug_we_i(debug_we_i), .debug_wdata_i(debug_wdata_i),
    .debug_rdata_o(debug_rdata_o), .debug_halted_o(debug_halted_o),
    .debug_halt_i(debug_halt_i), .debug_resume_i(debug_resume_i),
    .settings_o(settings_o), .trap_i(trap_i), .exc_cause_i(exc_cause_i),
    .stall_o(stall_o), .dbg_req_o(dbg_req_o), .dbg_ack_i(dbg_ack_i),
    .regfile_rreq_o(regfile_rreq_o), .regfile_raddr_o(regfile_raddr_o),
    .regfile_rdata_i(regfile_rdata_i), .regfile_wreq_o(regfile_wreq_o),
    .regfile_waddr_o(regfile_waddr_o), .regfile_wdata_o(regfile_wdata_o),
    .pc_if_i(pc_if_i), .pc_id_i(pc_id_i), .sleeping_i(sleeping_i),
    .jump_req_o(jump_req_o), .jump_addr_o(jump_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // register file model, every word tagged by its index, driven on rreq
  assign regfile_rdata_i = regfile_rreq_o ? regfile_raddr_o * 32'h0101_0101 : '0;

  // --------------------------------------------------
  // monitors and core model
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && regfile_wreq_o) begin
      rf_writes.push_back({regfile_waddr_o, regfile_wdata_o});
    end
    if (rst_n && jump_req_o) begin
      jumps.push_back(jump_addr_o);
    end
    // read request only in the rvalid cycle of a halted gpr read
    if (rst_n && regfile_rreq_o && !(debug_rvalid_o && debug_halted_o)) begin
      report_mismatch("regfile read request outside a halted read");
    end
  end

  // core acks a halt request after 1..4 cycles
  initial begin
    int seed_dummy;
    int delay;
    int cnt;
    dbg_ack_i  = 1'b0;
    seed_dummy = $urandom(3813);  // fixed ack delay sequence
    forever begin
      @(posedge clk);
      if (rst_n && dbg_req_o) begin
        delay = $urandom % 4 + 1;
        repeat (delay) @(posedge clk);
        #1 dbg_ack_i = 1'b1;
        @(posedge clk);
        #1 dbg_ack_i = 1'b0;
        cnt = 0;
        while (dbg_req_o && cnt < TMO) begin  // request drops after ack
          @(posedge clk);
          cnt++;
        end
        if (dbg_req_o) begin
          $display("timeout: dbg_req_o stayed high after the core ack");
          timeouts++;
        end
      end
    end
  end

  // --------------------------------------------------
  // tasks
  // --------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // one bus access, returns the data seen with rvalid
  task automatic bus_access(input logic we, input logic [`DBG_ADDR_W-1:0] addr,
                            input logic [`DBG_DATA_W-1:0] wdata,
                            output logic [`DBG_DATA_W-1:0] rdata);
    int cnt;
    debug_req_i   = 1'b1;
    debug_we_i    = we;
    debug_addr_i  = addr;
    debug_wdata_i = wdata;
    @(posedge clk);
    if (debug_gnt_o !== 1'b1) begin
      report_mismatch($sformatf("no grant for addr 0x%h", addr));
    end
    #1;
    debug_req_i = 1'b0;
    debug_we_i  = 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (debug_rvalid_o !== 1'b1 && cnt < TMO);
    rdata = debug_rdata_o;
    if (debug_rvalid_o !== 1'b1) begin
      $display("timeout: no rvalid for the access to addr 0x%h", addr);
      timeouts++;
    end else if (cnt != 1) begin
      report_mismatch($sformatf("rvalid %0d cycles after grant", cnt));
    end
    #1;
  endtask

  task automatic wait_halted(input logic level);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (debug_halted_o !== level && cnt < TMO);
    if (debug_halted_o !== level) begin
      $display("timeout: debug_halted_o did not become %0b", level);
      timeouts++;
    end
    #1;  // back to the drive point
  endtask

  // --------------------------------------------------
  // stim interpreter
  // --------------------------------------------------
  initial begin
    int fd;
    int nf;
    int line_no;
    string line;
    logic [63:0] op;
    logic [31:0] a, b, c, rdata;
    logic [`DBG_RF_ADDR_W+`DBG_DATA_W-1:0] wr_entry;

    errors     = 0;
    timeouts   = 0;
    rst_n          = 1'b0;
    debug_req_i    = 1'b0;
    debug_we_i     = 1'b0;
    debug_addr_i   = '0;
    debug_wdata_i  = '0;
    debug_halt_i   = 1'b0;
    debug_resume_i = 1'b0;
    trap_i         = 1'b0;
    exc_cause_i    = '0;
    pc_if_i        = '0;
    pc_id_i        = '0;
    sleeping_i     = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;

    line_no = 0;
    fd = $fopen("sim/dbg_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stim file sim/dbg_stim.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        op = '0;
        nf = $sscanf(line, "%s %h %h %h", op, a, b, c);
        if (nf < 1 || op == "#") begin
          continue;  // blank or comment
        end
        if (nf != 4) begin
          $display("malformed stim line %0d", line_no);
          errors++;
          continue;
        end
        case (op)
          "wr": begin
            bus_access(1'b1, a[`DBG_ADDR_W-1:0], b, rdata);
            if (rdata !== '0) begin
              report_mismatch($sformatf("line %0d write returned 0x%h", line_no, rdata));
            end
          end
          "rd": begin
            bus_access(1'b0, a[`DBG_ADDR_W-1:0], '0, rdata);
            if (rdata !== b) begin
              report_mismatch($sformatf("line %0d addr 0x%h read 0x%h exp 0x%h",
                                        line_no, a[14:0], rdata, b));
            end
          end
          "hpin": begin
            debug_halt_i = 1'b1;
            @(posedge clk);
            #1 debug_halt_i = 1'b0;
          end
          "rpin": begin
            debug_resume_i = 1'b1;
            #1;
            // stall drops in the resume cycle itself
            if (debug_halted_o === 1'b1 && stall_o !== 1'b0) begin
              report_mismatch($sformatf("line %0d stall_o high in the resume cycle", line_no));
            end
            @(posedge clk);
            #1 debug_resume_i = 1'b0;
          end
          "trap": begin
            trap_i      = 1'b1;
            exc_cause_i = a[`DBG_CAUSE_W-1:0];
            @(posedge clk);
            #1 trap_i = 1'b0;
          end
          "whalt": wait_halted(a[0]);
          "pcs": begin
            pc_if_i    = a;
            pc_id_i    = b;
            sleeping_i = c[0];
          end
          "stall": begin
            if (stall_o !== a[0]) begin
              report_mismatch($sformatf("line %0d stall_o %b exp %b", line_no, stall_o, a[0]));
            end
          end
          "set": begin
            if (settings_o !== a[4:0]) begin
              report_mismatch($sformatf("line %0d settings 0x%h exp 0x%h",
                                        line_no, settings_o, a[4:0]));
            end
          end
          "rfw": begin
            if (rf_writes.size() != 1) begin
              report_mismatch($sformatf("line %0d saw %0d regfile writes, exp 1",
                                        line_no, rf_writes.size()));
            end else begin
              wr_entry = rf_writes.pop_front();
              if (wr_entry !== {a[`DBG_RF_ADDR_W-1:0], b}) begin
                report_mismatch($sformatf("line %0d regfile write %0d/0x%h exp %0d/0x%h",
                                          line_no, wr_entry[36:32], wr_entry[31:0],
                                          a[4:0], b));
              end
            end
            rf_writes.delete();
          end
          "rfn": begin
            if (rf_writes.size() != 0) begin
              report_mismatch($sformatf("line %0d unexpected regfile write", line_no));
            end
            rf_writes.delete();
          end
          "jmp": begin
            if (jumps.size() != 1) begin
              report_mismatch($sformatf("line %0d saw %0d jump pulses, exp 1",
                                        line_no, jumps.size()));
            end else if (jumps[0] !== a) begin
              report_mismatch($sformatf("line %0d jump 0x%h exp 0x%h", line_no, jumps[0], a));
            end
            jumps.delete();
          end
          "jn": begin
            if (jumps.size() != 0) begin
              report_mismatch($sformatf("line %0d unexpected jump pulse", line_no));
            end
            jumps.delete();
          end
          default: begin
            $display("unknown stim operation on line %0d", line_no);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/dbg_pkg.sv
verilog/dbg_access_decode.sv
verilog/dbg_halt_ctrl.sv
verilog/dbg_read_mux.sv
verilog/dbg_unit.sv
sim/tb_dbg_unit.sv

/* verilog/dbg_access_decode.sv */
/*
 * debug bus access decode
 * grants every request, produces rvalid, owns the settings register
 * and turns writes into halt/resume, register file and jump strobes
 */

`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_access_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      debug_req_i,
  input  logic                      debug_we_i,
  input  logic [`DBG_ADDR_W-1:0]    debug_addr_i,
  input  logic [`DBG_DATA_W-1:0]    debug_wdata_i,
  input  logic                      halted_i,
  output logic                      debug_gnt_o,
  output logic                      debug_rvalid_o,
  output dbg_pkg::dbg_settings_t    settings_o,
  output logic                      halt_req_o,
  output logic                      resume_req_o,
  output logic                      hit_clear_o,
  output dbg_pkg::dbg_rsel_e        rsel_o,
  output logic [`DBG_RF_ADDR_W-1:0] reg_idx_o,
  output logic                      regfile_rreq_o,
  output logic                      regfile_wreq_o,
  output logic [`DBG_RF_ADDR_W-1:0] regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0]    regfile_wdata_o,
  output logic                      jump_req_o,
  output logic [`DBG_DATA_W-1:0]    jump_addr_o
);

  logic                      csr_acc;  // addr[14], dropped, reads zero
  logic [5:0]                grp;
  logic [`DBG_RF_ADDR_W-1:0] idx;

  dbg_pkg::dbg_settings_t    settings_q, settings_n;
  dbg_pkg::dbg_rsel_e        rsel_q, rsel_n;
  logic                      rreq_q, rreq_n;
  logic                      jump_q, jump_n;
  logic [`DBG_RF_ADDR_W-1:0] idx_q;
  logic [`DBG_DATA_W-1:0]    wdata_q;  // jump target

  assign csr_acc = debug_addr_i[14];
  assign grp     = debug_addr_i[13:8];
  assign idx     = debug_addr_i[6:2];

  // no back-pressure, every access granted
  assign debug_gnt_o = debug_req_i;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  always_comb begin
    rsel_n         = dbg_pkg::RSEL_NONE;
    rreq_n         = 1'b0;
    jump_n         = 1'b0;
    regfile_wreq_o = 1'b0;
    halt_req_o     = 1'b0;
    resume_req_o   = 1'b0;
    hit_clear_o    = 1'b0;
    settings_n     = settings_q;

    if (debug_req_i && !csr_acc) begin
      if (debug_we_i) begin
        case (grp)
          `DBG_GRP_ALWAYS: begin
            case (idx)
              `DBG_IDX_CTRL: begin
                if (debug_wdata_i[`DBG_CTRL_HALT_BIT]) begin
                  halt_req_o = !halted_i;  // only from running
                end else begin
                  resume_req_o = halted_i;
                end
                settings_n.sste = debug_wdata_i[0];
              end
              `DBG_IDX_HIT: hit_clear_o = debug_wdata_i[0];
              `DBG_IDX_IE: begin
                settings_n.ecall = debug_wdata_i[11];
                settings_n.elsu  = debug_wdata_i[7] | debug_wdata_i[5];
                settings_n.ebrk  = debug_wdata_i[3];
                settings_n.eill  = debug_wdata_i[2];
              end
              default: ;  // cause is read only
            endcase
          end
          `DBG_GRP_HALTED: jump_n = halted_i && (idx == `DBG_IDX_NPC);  // dnpc
          `DBG_GRP_GPR:    regfile_wreq_o = halted_i;
          default: ;
        endcase
      end else begin
        case (grp)
          `DBG_GRP_ALWAYS: rsel_n = dbg_pkg::RSEL_DBGA;
          `DBG_GRP_HALTED: begin
            if (halted_i) begin
              rsel_n = dbg_pkg::RSEL_DBGS;  // npc/ppc only while halted
            end
          end
          `DBG_GRP_GPR: begin
            if (halted_i) begin
              rreq_n = 1'b1;
              rsel_n = dbg_pkg::RSEL_GPR;
            end
          end
          default: ;  // unmapped, reads zero
        endcase
      end
    end
  end

  // --------------------------------------------------
  // registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_rvalid_o <= 1'b0;
      settings_q     <= '0;
      rsel_q         <= dbg_pkg::RSEL_NONE;
      rreq_q         <= 1'b0;
      jump_q         <= 1'b0;
    end else begin
      debug_rvalid_o <= debug_gnt_o;  // one cycle after grant
      settings_q     <= settings_n;
      // req or rvalid only, so one request fires once
      if (debug_req_i || debug_rvalid_o) begin
        rsel_q <= rsel_n;
        rreq_q <= rreq_n;
        jump_q <= jump_n;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      idx_q   <= idx;
      wdata_q <= debug_wdata_i;
    end
  end

  assign settings_o      = settings_q;
  assign rsel_o          = rsel_q;
  assign reg_idx_o       = idx_q;
  assign regfile_rreq_o  = rreq_q;
  assign regfile_waddr_o = idx;            // same cycle write
  assign regfile_wdata_o = debug_wdata_i;
  assign jump_req_o      = jump_q;
  assign jump_addr_o     = wdata_q;

endmodule

/* verilog/dbg_cfg.svh */
/*
 * debug unit configuration
 * bus widths, address group codes, register indices and the
 * cause code reported for a halt that did not come from a trap
 */

`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define DBG_ADDR_W     15  // debug bus address
`define DBG_DATA_W     32
`define DBG_RF_ADDR_W  5   // taken from addr[6:2]
`define DBG_CAUSE_W    6

`define DBG_CAUSE_HALT 6'd31  // halt via register or pin

// --------------------------------------------------
// address groups, addr[13:8]
// --------------------------------------------------
`define DBG_GRP_ALWAYS 6'h00  // always accessible
`define DBG_GRP_HALTED 6'h20  // halted only
`define DBG_GRP_GPR    6'h04  // general-purpose registers

// register indices, addr[6:2]
`define DBG_IDX_CTRL   5'd0
`define DBG_IDX_HIT    5'd1
`define DBG_IDX_IE     5'd2
`define DBG_IDX_CAUSE  5'd3
`define DBG_IDX_NPC    5'd0  // write side is DNPC
`define DBG_IDX_PPC    5'd1

`define DBG_CTRL_HALT_BIT 16  // halt when set, resume when clear

`endif

/* verilog/dbg_halt_ctrl.sv */
/*
 * halt control FSM
 * running -> halt request -> halt, handshakes with the core,
 * records the halt cause and the single-step hit flag
 */

`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_halt_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    halt_req_i,    // DBG_CTRL write
  input  logic                    resume_req_i,  // DBG_CTRL write
  input  logic                    hit_clear_i,   // DBG_HIT write
  input  dbg_pkg::dbg_settings_t  settings_i,
  input  logic                    debug_halt_i,
  input  logic                    debug_resume_i,
  input  logic                    trap_i,
  input  logic [`DBG_CAUSE_W-1:0] exc_cause_i,
  input  logic                    dbg_ack_i,
  output logic                    dbg_req_o,
  output logic                    stall_o,
  output logic                    halted_o,
  output logic [`DBG_CAUSE_W-1:0] cause_o,
  output logic                    hit_o
);

  typedef enum logic [1:0] {
    ST_RUN      = 2'd0,
    ST_HALT_REQ = 2'd1,
    ST_HALT     = 2'd2
  } state_e;

  state_e                  state_q, state_n;
  logic [`DBG_CAUSE_W-1:0] cause_q, cause_n;
  logic                    hit_q, hit_n;
  logic                    resume;

  assign resume = resume_req_i | debug_resume_i;

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    state_n   = state_q;
    cause_n   = cause_q;
    hit_n     = hit_q;
    dbg_req_o = 1'b0;
    stall_o   = 1'b0;
    halted_o  = 1'b0;

    case (state_q)
      ST_RUN: begin
        hit_n = 1'b0;
        if (halt_req_i || debug_halt_i || trap_i) begin
          dbg_req_o = 1'b1;  // raised in the trigger cycle
          state_n   = ST_HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            hit_n   = settings_i.sste;  // step hit
          end else begin
            cause_n = `DBG_CAUSE_HALT;
          end
        end
      end
      ST_HALT_REQ: begin
        dbg_req_o = 1'b1;  // hold until ack
        if (dbg_ack_i) begin
          state_n = ST_HALT;
        end
        if (resume) begin
          state_n = ST_RUN;  // resume wins over ack
        end
      end
      ST_HALT: begin
        halted_o = 1'b1;
        stall_o  = !resume;  // release stall in the resume cycle
        if (resume) begin
          state_n = ST_RUN;
        end
      end
      default: state_n = ST_RUN;
    endcase

    if (hit_clear_i) begin
      hit_n = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
      cause_q <= `DBG_CAUSE_HALT;
      hit_q   <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      hit_q   <= hit_n;
    end
  end

  assign cause_o = cause_q;
  assign hit_o   = hit_q;

endmodule

/* verilog/dbg_pkg.sv */
/*
 * debug unit types
 * read data source select and the debug settings struct
 * shared by decode, halt control and read mux
 */

package dbg_pkg;

  // --------------------------------------------------
  // read data source, registered in the decode block
  // --------------------------------------------------
  typedef enum logic [1:0] {
    RSEL_NONE = 2'd0,  // writes, csr group, disallowed, unmapped
    RSEL_GPR  = 2'd1,  // register file read data
    RSEL_DBGA = 2'd2,  // always accessible debug regs
    RSEL_DBGS = 2'd3   // halted-only regs (npc/ppc)
  } dbg_rsel_e;

  // --------------------------------------------------
  // debug settings handed to the core
  // --------------------------------------------------
  typedef struct packed {
    logic sste;   // single step enable
    logic ecall;  // halt on ecall
    logic elsu;   // halt on load/store fault
    logic ebrk;   // halt on ebreak
    logic eill;   // halt on illegal insn
  } dbg_settings_t;

  // sste comes from DBG_CTRL bit 0
  // the rest come from DBG_IE bits 11, 7|5, 3, 2

endpackage

/* verilog/dbg_read_mux.sv */
/*
 * debug read data mux
 * forms the debug register values and picks the bus read data
 * from the registered read source, valid while rvalid is high
 */

`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_read_mux (
  input  dbg_pkg::dbg_rsel_e        rsel_i,
  input  logic [`DBG_RF_ADDR_W-1:0] reg_idx_i,
  input  dbg_pkg::dbg_settings_t    settings_i,
  input  logic                      halted_i,
  input  logic                      sleeping_i,
  input  logic                      hit_i,
  input  logic [`DBG_CAUSE_W-1:0]   cause_i,
  input  logic [`DBG_DATA_W-1:0]    pc_if_i,
  input  logic [`DBG_DATA_W-1:0]    pc_id_i,
  input  logic [`DBG_DATA_W-1:0]    regfile_rdata_i,
  output logic [`DBG_DATA_W-1:0]    debug_rdata_o
);

  logic [`DBG_DATA_W-1:0] dbga_rdata;  // always accessible group
  logic [`DBG_DATA_W-1:0] dbgs_rdata;  // halted-only group

  // --------------------------------------------------
  // always accessible registers
  // --------------------------------------------------
  always_comb begin
    dbga_rdata = '0;
    case (reg_idx_i)
      `DBG_IDX_CTRL: begin
        dbga_rdata[16] = halted_i;
        dbga_rdata[0]  = settings_i.sste;
      end
      `DBG_IDX_HIT: begin
        dbga_rdata[16] = sleeping_i;
        dbga_rdata[0]  = hit_i;
      end
      `DBG_IDX_IE: begin
        dbga_rdata[11] = settings_i.ecall;
        dbga_rdata[7]  = settings_i.elsu;  // elsu shows twice
        dbga_rdata[5]  = settings_i.elsu;
        dbga_rdata[3]  = settings_i.ebrk;
        dbga_rdata[2]  = settings_i.eill;
      end
      `DBG_IDX_CAUSE: begin
        dbga_rdata[31]  = cause_i[5];  // interrupt flag
        dbga_rdata[4:0] = cause_i[4:0];
      end
      default: ;  // breakpoint regs etc read zero
    endcase
  end

  // npc/ppc straight from the pipeline
  always_comb begin
    case (reg_idx_i)
      `DBG_IDX_NPC: dbgs_rdata = pc_if_i;
      `DBG_IDX_PPC: dbgs_rdata = pc_id_i;
      default:      dbgs_rdata = '0;
    endcase
  end

  // --------------------------------------------------
  // output select
  // --------------------------------------------------
  always_comb begin
    case (rsel_i)
      dbg_pkg::RSEL_GPR:  debug_rdata_o = regfile_rdata_i;
      dbg_pkg::RSEL_DBGA: debug_rdata_o = dbga_rdata;
      dbg_pkg::RSEL_DBGS: debug_rdata_o = dbgs_rdata;
      default:            debug_rdata_o = '0;  // writes, unmapped, csr
    endcase
  end

endmodule

/* verilog/dbg_unit.sv */
/*
 * debug unit top
 * debug bus access decode, halt control and read data mux
 */

`timescale 1ns/1ps
`include "dbg_cfg.svh"

module dbg_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  // debugger bus
  input  logic                      debug_req_i,
  output logic                      debug_gnt_o,
  output logic                      debug_rvalid_o,
  input  logic [`DBG_ADDR_W-1:0]    debug_addr_i,
  input  logic                      debug_we_i,
  input  logic [`DBG_DATA_W-1:0]    debug_wdata_i,
  output logic [`DBG_DATA_W-1:0]    debug_rdata_o,
  // halt pins
  output logic                      debug_halted_o,
  input  logic                      debug_halt_i,
  input  logic                      debug_resume_i,
  // core side
  output dbg_pkg::dbg_settings_t    settings_o,
  input  logic                      trap_i,
  input  logic [`DBG_CAUSE_W-1:0]   exc_cause_i,
  output logic                      stall_o,
  output logic                      dbg_req_o,
  input  logic                      dbg_ack_i,
  // register file
  output logic                      regfile_rreq_o,
  output logic [`DBG_RF_ADDR_W-1:0] regfile_raddr_o,
  input  logic [`DBG_DATA_W-1:0]    regfile_rdata_i,
  output logic                      regfile_wreq_o,
  output logic [`DBG_RF_ADDR_W-1:0] regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0]    regfile_wdata_o,
  // pc and status
  input  logic [`DBG_DATA_W-1:0]    pc_if_i,
  input  logic [`DBG_DATA_W-1:0]    pc_id_i,
  input  logic                      sleeping_i,
  output logic                      jump_req_o,
  output logic [`DBG_DATA_W-1:0]    jump_addr_o
);

  logic                    halt_req;
  logic                    resume_req;
  logic                    hit_clear;
  logic                    hit;
  logic [`DBG_CAUSE_W-1:0] cause;
  dbg_pkg::dbg_rsel_e      rsel;

  // --------------------------------------------------
  // bus decode
  // --------------------------------------------------
  dbg_access_decode i_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .debug_we_i      (debug_we_i),
    .debug_addr_i    (debug_addr_i),
    .debug_wdata_i   (debug_wdata_i),
    .halted_i        (debug_halted_o),
    .debug_gnt_o     (debug_gnt_o),
    .debug_rvalid_o  (debug_rvalid_o),
    .settings_o      (settings_o),
    .halt_req_o      (halt_req),
    .resume_req_o    (resume_req),
    .hit_clear_o     (hit_clear),
    .rsel_o          (rsel),
    .reg_idx_o       (regfile_raddr_o),  // latched index
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (jump_addr_o)
  );

  // halt FSM
  dbg_halt_ctrl i_halt_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .halt_req_i     (halt_req),
    .resume_req_i   (resume_req),
    .hit_clear_i    (hit_clear),
    .settings_i     (settings_o),
    .debug_halt_i   (debug_halt_i),
    .debug_resume_i (debug_resume_i),
    .trap_i         (trap_i),
    .exc_cause_i    (exc_cause_i),
    .dbg_ack_i      (dbg_ack_i),
    .dbg_req_o      (dbg_req_o),
    .stall_o        (stall_o),
    .halted_o       (debug_halted_o),
    .cause_o        (cause),
    .hit_o          (hit)
  );

  // read data
  dbg_read_mux i_read_mux (
    .rsel_i          (rsel),
    .reg_idx_i       (regfile_raddr_o),
    .settings_i      (settings_o),
    .halted_i        (debug_halted_o),
    .sleeping_i      (sleeping_i),
    .hit_i           (hit),
    .cause_i         (cause),
    .pc_if_i         (pc_if_i),
    .pc_id_i         (pc_id_i),
    .regfile_rdata_i (regfile_rdata_i),
    .debug_rdata_o   (debug_rdata_o)
  );

endmodule
